/* build.f */
common/zynq_shell_pkg.sv
hdl/csr_file.sv
hdl/addr_map/addr_map.sv
hdl/mem_profiler.sv
hdl/zynq_shell_top.sv
verif/tb_zynq_shell_assertions.sv
verif/tb_zynq_shell.sv

/* common/zynq_shell_pkg.sv */
`default_nettype none

package zynq_shell_pkg;

   // core addresses and host physical DRAM addresses are both 32 bits
   localparam int axi_addr_width_lp = 32;

   // the host window bus drops the top two address bits before they reach us
   localparam int host_addr_width_lp = 30;

   // every CSR word is a full 32-bit register
   localparam int csr_data_width_lp = 32;

   // byte addressed CSR space, so the word index starts at bit 2
   localparam int csr_addr_width_lp = 6;

   typedef logic [axi_addr_width_lp-1:0]  axi_addr_t;
   typedef logic [host_addr_width_lp-1:0] host_addr_t;
   typedef logic [csr_data_width_lp-1:0]  csr_data_t;
   typedef logic [csr_addr_width_lp-1:0]  csr_addr_t;

   // the core sees its DRAM starting here
   // remapping strips this base with an xor rather than a subtract
   localparam axi_addr_t core_dram_base_lp = 32'h8000_0000;

   // the host allocates 120 MiB for the core, measured from the base
   localparam axi_addr_t mem_upper_limit_lp = 120*1024*1024;

   // one profiler bit per region of core address space
   localparam int profiler_regions_lp = 128;

   // region index is the seven bits counting down from this one
   localparam int profiler_index_msb_lp = 29;

   // writable CSR words
   localparam int csr_reset_idx_lp      = 0;
   localparam int csr_dram_alloc_idx_lp = 1;
   localparam int csr_dram_base_idx_lp  = 2;

   // read-only profiler words occupy indices 3 to 6
   // the lowest numbered regions sit in the first of them
   localparam int csr_prof_first_idx_lp = 3;

endpackage

`default_nettype wire

/* hdl/addr_map/addr_map.sv */
`timescale 1ns/100ps
`default_nettype none

module addr_map
   import zynq_shell_pkg::*;
  (input wire                aclk_i
   , input wire              rst_n_i

   // host window request, host address space
   , input wire              host_req_v_i
   , input wire              host_we_i
   , input wire host_addr_t  host_addr_i
   , input wire csr_data_t   host_wdata_i

   // allocated host DRAM buffer
   , input wire axi_addr_t   dram_base_i

   // core DRAM request, core address space
   , input wire              dram_req_v_i
   , input wire              dram_we_i
   , input wire axi_addr_t   dram_addr_i

   // host request as the core sees it
   , output logic            core_req_v_o
   , output logic            core_we_o
   , output axi_addr_t       core_addr_o
   , output csr_data_t       core_wdata_o

   // core request as host DRAM sees it
   , output logic            ps_req_v_o
   , output logic            ps_we_o
   , output axi_addr_t       ps_addr_o
   , output logic            ps_oob_o
   );

   axi_addr_t host_xlat;
   axi_addr_t dram_offset;
   axi_addr_t ps_addr_n;
   logic      oob_n;

   logic      core_req_v_r;
   logic      core_we_r;
   axi_addr_t core_addr_r;
   csr_data_t core_wdata_r;

   logic      ps_req_v_r;
   logic      ps_we_r;
   axi_addr_t ps_addr_r;
   logic      ps_oob_r;

   // host window 0x0000_0000 lands on core DRAM at 0x8000_0000
   // host window 0x2000_0000 lands on core local space at 0x0000_0000
   // so the top host bit is inverted into the top core bit and the gap is zero filled
   always_comb
   begin
      host_xlat = '0;
      host_xlat[axi_addr_width_lp-1] = ~host_addr_i[host_addr_width_lp-1];
      host_xlat[host_addr_width_lp-3:0] = host_addr_i[host_addr_width_lp-3:0];
   end

   // strip the core DRAM base, then slide the offset into the host buffer
   // offsets at or past the allocated size get flagged rather than blocked
   always_comb
   begin
      dram_offset = dram_addr_i ^ core_dram_base_lp;
      ps_addr_n   = dram_offset + dram_base_i;
      oob_n       = dram_req_v_i && (dram_offset >= mem_upper_limit_lp);
   end

   // valids and the limit flag are the only state that needs a reset
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         core_req_v_r <= 1'b0;
         ps_req_v_r   <= 1'b0;
         ps_oob_r     <= 1'b0;
      end
      else
      begin
         core_req_v_r <= host_req_v_i;
         ps_req_v_r   <= dram_req_v_i;
         ps_oob_r     <= oob_n;
      end
   end

   // payload moves only with a request, both paths independent
   always_ff @(posedge aclk_i)
   begin
      if (host_req_v_i)
      begin
         core_we_r    <= host_we_i;
         core_addr_r  <= host_xlat;
         core_wdata_r <= host_wdata_i;
      end
      if (dram_req_v_i)
      begin
         ps_we_r   <= dram_we_i;
         ps_addr_r <= ps_addr_n;
      end
   end

   assign core_req_v_o = core_req_v_r;
   assign core_we_o    = core_we_r;
   assign core_addr_o  = core_addr_r;
   assign core_wdata_o = core_wdata_r;

   assign ps_req_v_o   = ps_req_v_r;
   assign ps_we_o      = ps_we_r;
   assign ps_addr_o    = ps_addr_r;
   assign ps_oob_o     = ps_oob_r;

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file
   import zynq_shell_pkg::*;
  (input wire                          aclk_i
   , input wire                        rst_n_i
   , input wire                        csr_wr_v_i
   , input wire                        csr_rd_v_i
   , input wire csr_addr_t             csr_addr_i
   , input wire csr_data_t             csr_wdata_i
   , input wire [profiler_regions_lp-1:0] prof_map_i
   , output logic                      csr_rvalid_o
   , output csr_data_t                 csr_rdata_o
   , output axi_addr_t                 dram_base_o
   , output logic                      core_rst_n_o
   );

   // word index into the CSR space, byte offset bits dropped
   logic [csr_addr_width_lp-3:0] csr_idx;

   // host writable registers
   csr_data_t reset_r;
   csr_data_t dram_alloc_r;
   csr_data_t dram_base_r;

   // read-back path
   csr_data_t rdata_n;
   csr_data_t rdata_r;
   logic      rvalid_r;

   // registered core reset, low true
   logic      core_rst_n_r;

   // the profiler bitmap seen as a stack of CSR words
   logic [profiler_regions_lp/csr_data_width_lp-1:0][csr_data_width_lp-1:0] prof_words;

   assign csr_idx    = csr_addr_i[csr_addr_width_lp-1:2];
   assign prof_words = prof_map_i;

   // only the first three words take writes
   // anything written elsewhere is dropped without a trace
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         reset_r      <= '0;
         dram_alloc_r <= '0;
         dram_base_r  <= '0;
      end
      else if (csr_wr_v_i)
      begin
         case (csr_idx)
            csr_reset_idx_lp:      reset_r      <= csr_wdata_i;
            csr_dram_alloc_idx_lp: dram_alloc_r <= csr_wdata_i;
            csr_dram_base_idx_lp:  dram_base_r  <= csr_wdata_i;
            default:               ;
         endcase
      end
   end

   // read mux, unmapped words come back as zero
   // the profiler words follow the writable ones, lowest regions first
   always_comb
   begin
      rdata_n = '0;
      case (csr_idx)
         csr_reset_idx_lp:      rdata_n = reset_r;
         csr_dram_alloc_idx_lp: rdata_n = dram_alloc_r;
         csr_dram_base_idx_lp:  rdata_n = dram_base_r;
         default:               rdata_n = '0;
      endcase
      for (int i = 0; i < profiler_regions_lp/csr_data_width_lp; i++)
      begin
         if (csr_idx == csr_prof_first_idx_lp + i)
            rdata_n = prof_words[i];
      end
   end

   // a read answers exactly one cycle after its strobe
   always_ff @(posedge aclk_i)
   begin
      if (csr_rd_v_i)
         rdata_r <= rdata_n;
   end

   // the core comes out of reset only once bit 0 of the reset word is set
   // system reset pulls it straight back down without waiting for a clock
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rvalid_r     <= 1'b0;
         core_rst_n_r <= 1'b0;
      end
      else
      begin
         rvalid_r     <= csr_rd_v_i;
         core_rst_n_r <= reset_r[0];
      end
   end

   assign csr_rvalid_o = rvalid_r;
   assign csr_rdata_o  = rdata_r;
   assign dram_base_o  = dram_base_r;
   assign core_rst_n_o = core_rst_n_r;

endmodule

`default_nettype wire

/* hdl/mem_profiler.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_profiler
   import zynq_shell_pkg::*;
  (input wire                          aclk_i
   , input wire                        rst_n_i
   , input wire                        core_rst_n_i
   , input wire                        dram_req_v_i
   , input wire axi_addr_t             dram_addr_i
   , output logic [profiler_regions_lp-1:0] prof_map_o
   );

   // which region the current request falls in
   logic [$clog2(profiler_regions_lp)-1:0] region_idx;

   // one bit per region, set on first touch and held until the core is reset
   logic [profiler_regions_lp-1:0] prof_map_r;
   logic [profiler_regions_lp-1:0] prof_map_n;

   // regions are 8 MiB slices taken from the raw core address
   assign region_idx = dram_addr_i[profiler_index_msb_lp -: $clog2(profiler_regions_lp)];

   // bits only ever get set here
   always_comb
   begin
      prof_map_n = prof_map_r;
      if (dram_req_v_i)
         prof_map_n[region_idx] = 1'b1;
   end

   // holding the core in reset wipes the map for the next program
   // a request arriving in that window is not recorded
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         prof_map_r <= '0;
      else if (!core_rst_n_i)
         prof_map_r <= '0;
      else
         prof_map_r <= prof_map_n;
   end

   // the map reads as all zero for the whole time the core is held in reset
   assign prof_map_o = core_rst_n_i ? prof_map_r : '0;

endmodule

`default_nettype wire

/* hdl/zynq_shell_top.sv */
`timescale 1ns/100ps
`default_nettype none

module zynq_shell_top
   import zynq_shell_pkg::*;
  (input wire                aclk_i
   , input wire              rst_n_i

   // host control and status register port
   , input wire              csr_wr_v_i
   , input wire              csr_rd_v_i
   , input wire csr_addr_t   csr_addr_i
   , input wire csr_data_t   csr_wdata_i
   , output logic            csr_rvalid_o
   , output csr_data_t       csr_rdata_o

   // host window into the core
   , input wire              host_req_v_i
   , input wire              host_we_i
   , input wire host_addr_t  host_addr_i
   , input wire csr_data_t   host_wdata_i
   , output logic            core_req_v_o
   , output logic            core_we_o
   , output axi_addr_t       core_addr_o
   , output csr_data_t       core_wdata_o
   , output logic            core_rst_n_o

   // core DRAM requests heading for host physical memory
   , input wire              dram_req_v_i
   , input wire              dram_we_i
   , input wire axi_addr_t   dram_addr_i
   , output logic            ps_req_v_o
   , output logic            ps_we_o
   , output axi_addr_t       ps_addr_o
   , output logic            ps_oob_o
   );

   // base of the host DRAM buffer as last written by the host
   axi_addr_t                      dram_base_lo;

   // one sticky bit per profiled region, read back through the CSR file
   logic [profiler_regions_lp-1:0] prof_map_lo;

   // the CSR file owns the core reset and the DRAM base
   // core reset also feeds the profiler so that a new run starts with a clean map
   csr_file csr_file_inst
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.csr_wr_v_i   (csr_wr_v_i)
      ,.csr_rd_v_i   (csr_rd_v_i)
      ,.csr_addr_i   (csr_addr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.prof_map_i   (prof_map_lo)
      ,.csr_rvalid_o (csr_rvalid_o)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.dram_base_o  (dram_base_lo)
      ,.core_rst_n_o (core_rst_n_o)
      );

   // both address paths live here, each one register deep
   addr_map addr_map_inst
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.host_req_v_i (host_req_v_i)
      ,.host_we_i    (host_we_i)
      ,.host_addr_i  (host_addr_i)
      ,.host_wdata_i (host_wdata_i)
      ,.dram_base_i  (dram_base_lo)
      ,.dram_req_v_i (dram_req_v_i)
      ,.dram_we_i    (dram_we_i)
      ,.dram_addr_i  (dram_addr_i)
      ,.core_req_v_o (core_req_v_o)
      ,.core_we_o    (core_we_o)
      ,.core_addr_o  (core_addr_o)
      ,.core_wdata_o (core_wdata_o)
      ,.ps_req_v_o   (ps_req_v_o)
      ,.ps_we_o      (ps_we_o)
      ,.ps_addr_o    (ps_addr_o)
      ,.ps_oob_o     (ps_oob_o)
      );

   // the profiler watches raw core addresses, before any remapping
   mem_profiler mem_profiler_inst
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.core_rst_n_i (core_rst_n_o)
      ,.dram_req_v_i (dram_req_v_i)
      ,.dram_addr_i  (dram_addr_i)
      ,.prof_map_o   (prof_map_lo)
      );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the zynq shell testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_zynq_shell -f build.f -o sim_zynq_shell

# the log decides the outcome, so a nonzero simulator exit must not stop the script here
./obj_dir/sim_zynq_shell > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
   echo "simulation ok"
   exit 0
else
   echo "simulation reported a failure"
   exit 1
fi

/* verif/tb_zynq_shell.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_zynq_shell
   import zynq_shell_pkg::*;
   ();

   logic       aclk;
   logic       rst_n;
   logic       csr_wr_v;
   logic       csr_rd_v;
   csr_addr_t  csr_addr;
   csr_data_t  csr_wdata;
   logic       csr_rvalid;
   csr_data_t  csr_rdata;
   logic       host_req_v;
   logic       host_we;
   host_addr_t host_addr;
   csr_data_t  host_wdata;
   logic       core_req_v;
   logic       core_we;
   axi_addr_t  core_addr;
   csr_data_t  core_wdata;
   logic       core_rst_n;
   logic       dram_req_v;
   logic       dram_we;
   axi_addr_t  dram_addr;
   logic       ps_req_v;
   logic       ps_we;
   axi_addr_t  ps_addr;
   logic       ps_oob;

   // expected responses in issue order
   // core side packs {we, addr, data} and the ps side packs {we, oob, addr}
   csr_data_t   exp_rd_q[$];
   logic [64:0] exp_core_q[$];
   logic [33:0] exp_ps_q[$];

   integer    seed;
   string     test_name;
   int        test_errors;
   int        errors;
   int        checks;
   int        tests_run;
   axi_addr_t dram_base;
   logic [profiler_regions_lp-1:0] exp_map;

   zynq_shell_top zynq_shell_top_inst
     (.aclk_i        (aclk)
      ,.rst_n_i      (rst_n)
      ,.csr_wr_v_i   (csr_wr_v)
      ,.csr_rd_v_i   (csr_rd_v)
      ,.csr_addr_i   (csr_addr)
      ,.csr_wdata_i  (csr_wdata)
      ,.csr_rvalid_o (csr_rvalid)
      ,.csr_rdata_o  (csr_rdata)
      ,.host_req_v_i (host_req_v)
      ,.host_we_i    (host_we)
      ,.host_addr_i  (host_addr)
      ,.host_wdata_i (host_wdata)
      ,.core_req_v_o (core_req_v)
      ,.core_we_o    (core_we)
      ,.core_addr_o  (core_addr)
      ,.core_wdata_o (core_wdata)
      ,.core_rst_n_o (core_rst_n)
      ,.dram_req_v_i (dram_req_v)
      ,.dram_we_i    (dram_we)
      ,.dram_addr_i  (dram_addr)
      ,.ps_req_v_o   (ps_req_v)
      ,.ps_we_o      (ps_we)
      ,.ps_addr_o    (ps_addr)
      ,.ps_oob_o     (ps_oob)
      );

   // protocol checks ride along inside the top level
   bind zynq_shell_top tb_zynq_shell_assertions assertions_inst
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.csr_rd_v_i   (csr_rd_v_i)
      ,.csr_rvalid_i (csr_rvalid_o)
      ,.host_req_v_i (host_req_v_i)
      ,.core_req_v_i (core_req_v_o)
      ,.dram_req_v_i (dram_req_v_i)
      ,.ps_req_v_i   (ps_req_v_o)
      ,.core_rst_n_i (core_rst_n_o)
      );

   initial
   begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;
   end

   // host window rule, top bit inverted, three zero bits, low 28 copied
   function automatic axi_addr_t ref_host_xlat(host_addr_t a);
      return {~a[29], 3'b000, a[27:0]};
   endfunction

   // offset into the allocated buffer once the core DRAM base is stripped
   function automatic axi_addr_t ref_dram_offset(axi_addr_t a);
      return a ^ 32'h8000_0000;
   endfunction

   function automatic axi_addr_t ref_ps_addr(axi_addr_t a, axi_addr_t base);
      return ref_dram_offset(a) + base;
   endfunction

   // 120 MiB allocated, anything at or past that is out of bounds
   function automatic logic ref_oob(axi_addr_t a);
      return ref_dram_offset(a) >= 32'd125829120;
   endfunction

   // 8 MiB regions, seven bits down from bit 29
   function automatic int ref_region(axi_addr_t a);
      return int'(a[29:23]);
   endfunction

   task automatic check_value(string what, logic [127:0] exp, logic [127:0] got);
      checks++;
      assert (got == exp)
      else
      begin
         $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, exp, got);
         test_errors++;
      end
   endtask

   task automatic unexpected(string what);
      $display("%s: %s arrived with nothing outstanding", test_name, what);
      test_errors++;
   endtask

   // responses are stable around the falling edge
   always @(negedge aclk)
   begin
      if (csr_rvalid)
      begin
         if (exp_rd_q.size() == 0)
            unexpected("csr read data");
         else
            check_value("csr_rdata_o", exp_rd_q.pop_front(), csr_rdata);
      end
      if (core_req_v)
      begin
         if (exp_core_q.size() == 0)
            unexpected("core request");
         else
            check_value("core request", exp_core_q.pop_front(), {core_we, core_addr, core_wdata});
      end
      if (ps_req_v)
      begin
         if (exp_ps_q.size() == 0)
            unexpected("ps request");
         else
            check_value("ps request", exp_ps_q.pop_front(), {ps_we, ps_oob, ps_addr});
      end
   end

   // all drives land 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge aclk);
      #1;
   endtask

   task automatic csr_write(int idx, csr_data_t data);
      csr_wr_v  = 1'b1;
      csr_addr  = csr_addr_t'(idx * 4);
      csr_wdata = data;
      next_cycle();
      csr_wr_v  = 1'b0;
   endtask

   task automatic csr_read(int idx, csr_data_t exp);
      exp_rd_q.push_back(exp);
      csr_rd_v = 1'b1;
      csr_addr = csr_addr_t'(idx * 4);
      next_cycle();
      csr_rd_v = 1'b0;
   endtask

   // one cycle of a DRAM request, the caller drops the strobe after a burst
   task automatic dram_drive(axi_addr_t a, logic we);
      exp_ps_q.push_back({we, ref_oob(a), ref_ps_addr(a, dram_base)});
      dram_req_v = 1'b1;
      dram_we    = we;
      dram_addr  = a;
      next_cycle();
   endtask

   task automatic wait_core_reset(logic level);
      int n;
      n = 0;
      while (core_rst_n !== level && n < 20)
      begin
         next_cycle();
         n++;
      end
      if (core_rst_n !== level)
      begin
         $display("%s: core reset output never went to %0b", test_name, level);
         test_errors++;
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((exp_rd_q.size() + exp_core_q.size() + exp_ps_q.size()) != 0 && n < 50)
      begin
         next_cycle();
         n++;
      end
      if ((exp_rd_q.size() + exp_core_q.size() + exp_ps_q.size()) != 0)
      begin
         $display("%s: timed out with responses still missing", test_name);
         test_errors++;
         exp_rd_q.delete();
         exp_core_q.delete();
         exp_ps_q.delete();
      end
   endtask

   task automatic begin_test(string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      drain();
      tests_run++;
      errors += test_errors;
      $display("test %-9s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "bad",
               test_errors);
   endtask

   task automatic test_reset();
      check_value("csr_rvalid_o", 0, csr_rvalid);
      check_value("core_req_v_o", 0, core_req_v);
      check_value("ps_req_v_o", 0, ps_req_v);
      check_value("ps_oob_o", 0, ps_oob);
      check_value("core_rst_n_o", 0, core_rst_n);
      for (int i = 0; i < 7; i++)
         csr_read(i, '0);
   endtask

   task automatic test_csr();
      csr_data_t v;
      // bit 0 of the reset word stays clear so the core is still held
      v = $random(seed) & 32'hffff_fffe;
      csr_write(0, v);
      csr_read(0, v);
      for (int i = 1; i < 3; i++)
      begin
         v = $random(seed);
         csr_write(i, v);
         csr_read(i, v);
      end
      // a profiler word and an unmapped word both ignore writes
      csr_write(5, $random(seed));
      csr_read(5, '0);
      csr_write(9, $random(seed));
      csr_read(9, '0);
      csr_write(0, 32'd1);
      wait_core_reset(1'b1);
      csr_write(0, 32'd0);
      wait_core_reset(1'b0);
      // system reset pulls a released core down at once and clears the reset word
      csr_write(0, 32'd1);
      wait_core_reset(1'b1);
      rst_n = 1'b0;
      #1;
      check_value("core_rst_n_o in reset", 0, core_rst_n);
      next_cycle();
      next_cycle();
      rst_n = 1'b1;
      check_value("core_rst_n_o after reset", 0, core_rst_n);
      csr_read(0, '0);
   endtask

   task automatic test_host();
      for (int i = 0; i < 24; i++)
      begin
         host_req_v = 1'b1;
         host_we    = $random(seed);
         host_addr  = host_addr_t'($random(seed));
         host_wdata = $random(seed);
         exp_core_q.push_back({host_we, ref_host_xlat(host_addr), host_wdata});
         next_cycle();
      end
      host_req_v = 1'b0;
   endtask

   task automatic test_dram();
      axi_addr_t a;
      dram_base = $random(seed) & 32'hffff_f000;
      csr_write(2, dram_base);
      // offsets up to 128 MiB so a few land past the limit
      for (int i = 0; i < 16; i++)
      begin
         a = 32'h8000_0000 | (axi_addr_t'($random(seed)) & 32'h07ff_ffff);
         dram_drive(a, $random(seed));
      end
      dram_drive(32'h8000_0000 + 32'd125829119, 1'b0);
      dram_drive(32'h8000_0000 + 32'd125829120, 1'b1);
      dram_drive(32'h8000_0000 + 32'd125829121, 1'b0);
      // below the core base the offset wraps high
      dram_drive(axi_addr_t'($random(seed)) & 32'h7fff_ffff, 1'b1);
      dram_req_v = 1'b0;
   endtask

   task automatic test_profiler();
      axi_addr_t a;
      int        r;
      exp_map = '0;
      csr_write(0, 32'd1);
      wait_core_reset(1'b1);
      for (int i = 0; i < 8; i++)
      begin
         r = (i == 0) ? 0 : (i == 1) ? 127 : ($random(seed) & 127);
         a = $random(seed);
         a[29:23] = 7'(r);
         exp_map[ref_region(a)] = 1'b1;
         dram_drive(a, $random(seed));
      end
      dram_req_v = 1'b0;
      for (int i = 0; i < 4; i++)
         csr_read(3 + i, exp_map[32*i +: 32]);
      csr_write(0, 32'd0);
      wait_core_reset(1'b0);
      for (int i = 0; i < 4; i++)
         csr_read(3 + i, '0);
   endtask

   initial
   begin
      seed        = 32'h6d11;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      test_errors = 0;
      test_name   = "init";
      dram_base   = '0;
      exp_map     = '0;
      rst_n       = 1'b0;
      csr_wr_v    = 1'b0;
      csr_rd_v    = 1'b0;
      csr_addr    = '0;
      csr_wdata   = '0;
      host_req_v  = 1'b0;
      host_we     = 1'b0;
      host_addr   = '0;
      host_wdata  = '0;
      dram_req_v  = 1'b0;
      dram_we     = 1'b0;
      dram_addr   = '0;
      repeat (2) @(posedge aclk);
      #1;
      rst_n = 1'b1;

      begin_test("reset");
      test_reset();
      end_test();
      begin_test("csr");
      test_csr();
      end_test();
      begin_test("host");
      test_host();
      end_test();
      begin_test("dram");
      test_dram();
      end_test();
      begin_test("profiler");
      test_profiler();
      end_test();

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tb_zynq_shell_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_zynq_shell_assertions
  (input wire   aclk_i
   , input wire rst_n_i
   , input wire csr_rd_v_i
   , input wire csr_rvalid_i
   , input wire host_req_v_i
   , input wire core_req_v_i
   , input wire dram_req_v_i
   , input wire ps_req_v_i
   , input wire core_rst_n_i
   );

   // each response valid is its strobe delayed by exactly one clock
   rvalid_follows_read: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      csr_rvalid_i == $past(csr_rd_v_i))
   else
      $error("csr read valid is not the read strobe one cycle later");

   core_follows_host: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      core_req_v_i == $past(host_req_v_i))
   else
      $error("core request valid is not the host strobe one cycle later");

   ps_follows_dram: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      ps_req_v_i == $past(dram_req_v_i))
   else
      $error("ps request valid is not the dram strobe one cycle later");

   // system reset holds the core down
   core_held_in_reset: assert property (@(posedge aclk_i) !rst_n_i |-> !core_rst_n_i)
   else
      $error("core reset released while system reset is active");

endmodule

`default_nettype wire
